// ==== rtl/cache_ctrl.sv ====
// cache controller that runs the miss FSM and drives the memory bus for the cache top level
`timescale 1ns/1ps

module cache_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    // load/store port
    input  logic               valid_in,
    input  logic               write,
    input  cache_pkg::len_t    len,
    input  cache_pkg::addr_t   addr,
    input  cache_pkg::word_t   data_in,
    output logic               addr_ok,
    output logic               data_ok,
    // memory bus
    output logic               r_req,
    output cache_pkg::addr_t   r_addr,
    input  logic               r_rdy,
    input  logic               re_valid,
    output logic               w_req,
    output cache_pkg::addr_t   w_addr,
    input  logic               w_rdy,
    // tag array results
    input  logic               hit,
    input  logic               hit_way,
    input  logic               victim_dirty,
    input  cache_pkg::tag_t    victim_tag,
    // array control
    output cache_pkg::index_t  arr_index,
    output logic               rd_en,
    output logic               tag_fill,
    output logic               tag_mark_dirty,
    output logic               fill_dirty,
    output logic               data_wr_en,
    output logic               victim_way,
    output logic               sel_way,
    output logic               from_mem,
    // request fields for the line merge
    output cache_pkg::tag_t    req_tag,
    output cache_pkg::offset_t req_offset,
    output cache_pkg::len_t    req_len,
    output cache_pkg::word_t   req_data
);

    cache_pkg::cache_state_t state;
    cache_pkg::cache_state_t state_next;

    cache_pkg::addr_t  req_addr;
    cache_pkg::index_t req_index;
    logic              req_write;
    logic              victim_q;
    logic              accept;
    logic              read_hit;

    //////////////////////////////////////////////////
    // request capture
    //////////////////////////////////////////////////
    assign read_hit = (state == cache_pkg::LOOKUP) && hit && !req_write;
    assign addr_ok  = (state == cache_pkg::IDLE) || read_hit; // back-to-back reads on hit
    assign accept   = valid_in && addr_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_write <= 1'b0;
        end else if (accept) begin
            req_write <= write;
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= addr;
            req_data <= data_in;
            req_len  <= len;
        end
    end

    assign {req_tag, req_index, req_offset} = req_addr;
    assign fill_dirty = req_write; // a write miss lands dirty

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::IDLE: begin
                if (valid_in) state_next = cache_pkg::LOOKUP;
            end
            cache_pkg::LOOKUP: begin
                if (!hit) begin
                    state_next = cache_pkg::MISS;
                end else if (req_write) begin
                    state_next = cache_pkg::WRITE;
                end else if (!valid_in) begin
                    state_next = cache_pkg::IDLE; // stay while the next read is taken
                end
            end
            cache_pkg::MISS: begin
                if (!victim_dirty || w_rdy) state_next = cache_pkg::REPLACE;
            end
            cache_pkg::REPLACE: begin
                if (r_rdy) state_next = cache_pkg::REFILL;
            end
            cache_pkg::REFILL: begin
                if (re_valid) state_next = cache_pkg::IDLE;
            end
            cache_pkg::WRITE: state_next = cache_pkg::IDLE;
            default: state_next = cache_pkg::IDLE;
        endcase
    end

    // victim pick flips each lookup cycle and holds from MISS through REFILL
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_q <= 1'b0;
        end else if (state == cache_pkg::LOOKUP) begin
            victim_q <= ~victim_q;
        end
    end

    assign victim_way = victim_q;

    //////////////////////////////////////////////////
    // array control
    //////////////////////////////////////////////////
    // held index unless a request can be taken
    assign arr_index = addr_ok ? addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W] : req_index;
    assign rd_en     = accept;

    assign tag_fill       = (state == cache_pkg::REFILL) && re_valid;
    assign tag_mark_dirty = (state == cache_pkg::WRITE);
    assign data_wr_en     = tag_fill || (state == cache_pkg::WRITE); // whole line each time

    // hit way on a hit and the victim way for write-back and refill
    assign sel_way  = ((state == cache_pkg::LOOKUP) || (state == cache_pkg::WRITE)) ?
                      hit_way : victim_q;
    assign from_mem = (state == cache_pkg::REFILL);

    assign data_ok = read_hit || ((state == cache_pkg::REFILL) && re_valid && !req_write);

    //////////////////////////////////////////////////
    // memory bus
    //////////////////////////////////////////////////
    assign w_req  = (state == cache_pkg::MISS) && victim_dirty; // held until w_rdy
    assign w_addr = {victim_tag, req_index, cache_pkg::offset_t'(0)};
    assign r_req  = (state == cache_pkg::REPLACE);
    assign r_addr = {req_tag, req_index, cache_pkg::offset_t'(0)}; // line aligned

    // stalled write-back keeps its victim and no fetch starts meanwhile
    assert property (@(posedge clk) disable iff (!rst_n)
        w_req && !w_rdy |=> w_req && !r_req && $stable(w_addr));

    // stalled fetch keeps its line address
    assert property (@(posedge clk) disable iff (!rst_n)
        r_req && !r_rdy |=> r_req && $stable(r_addr));

endmodule

// ==== rtl/cache_pkg.sv ====
// shared widths, vector types and controller states for the data cache, used by scoped name
package cache_pkg;

    //////////////////////////////////////////////////
    // address split and bus widths
    //////////////////////////////////////////////////
    localparam int ADDR_W   = 32;  // byte address
    localparam int WORD_W   = 64;  // load/store port
    localparam int LINE_W   = 256; // one line, also the memory bus
    localparam int TAG_W    = 21;
    localparam int INDEX_W  = 6;   // 64 sets
    localparam int OFFSET_W = 5;   // 32 bytes per line

    //////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // write size code
    // 0 = 1 byte, 1 = 2 bytes, 2 = 4 bytes, 3 = 8 bytes
    typedef logic [1:0] len_t;

    //////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,    // waiting for a request
        LOOKUP,  // tags and lines of the set are out, compare
        MISS,    // write back a dirty victim
        REPLACE, // ask memory for the missing line
        REFILL,  // wait for the line to come back
        WRITE    // store hit data into the line
    } cache_state_t;

endpackage

// ==== rtl/cache_top.sv ====
// data cache top level, joins controller, tag array, data array and line merge to the ports
`timescale 1ns/1ps

module cache_top (
    input  logic             clk,
    input  logic             rst_n,
    // load/store port
    input  cache_pkg::addr_t addr,
    input  cache_pkg::word_t data_in,
    input  logic             valid_in,
    input  logic             write,
    input  cache_pkg::len_t  len,
    output logic             addr_ok,
    output logic             data_ok,
    output cache_pkg::word_t data_out,
    // memory read channel
    output logic             r_req,
    output cache_pkg::addr_t r_addr,
    input  logic             r_rdy,
    input  cache_pkg::line_t re_data,
    input  logic             re_valid,
    // memory write channel
    output logic             w_req,
    output cache_pkg::addr_t w_addr,
    output cache_pkg::line_t w_data,
    input  logic             w_rdy
);

    // array control from the controller
    cache_pkg::index_t  arr_index;
    logic               rd_en;
    logic               tag_fill;
    logic               tag_mark_dirty;
    logic               req_write;     // registered write flag, also the fill dirty value
    logic               data_wr_en;
    logic               victim_way;
    logic               sel_way;
    logic               from_mem;

    // registered request fields
    cache_pkg::tag_t    req_tag;
    cache_pkg::offset_t req_offset;
    cache_pkg::len_t    req_len;
    cache_pkg::word_t   req_data;

    // array results
    logic               hit;
    logic               hit_way;
    cache_pkg::tag_t    victim_tag;
    logic               victim_dirty;
    cache_pkg::line_t   way0_line;
    cache_pkg::line_t   way1_line;
    cache_pkg::line_t   merged_line;

    cache_ctrl u_cache_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_in       (valid_in),
        .write          (write),
        .len            (len),
        .addr           (addr),
        .data_in        (data_in),
        .addr_ok        (addr_ok),
        .data_ok        (data_ok),
        .r_req          (r_req),
        .r_addr         (r_addr),
        .r_rdy          (r_rdy),
        .re_valid       (re_valid),
        .w_req          (w_req),
        .w_addr         (w_addr),
        .w_rdy          (w_rdy),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_dirty   (victim_dirty),
        .victim_tag     (victim_tag),
        .arr_index      (arr_index),
        .rd_en          (rd_en),
        .tag_fill       (tag_fill),
        .tag_mark_dirty (tag_mark_dirty),
        .fill_dirty     (req_write),
        .data_wr_en     (data_wr_en),
        .victim_way     (victim_way),
        .sel_way        (sel_way),
        .from_mem       (from_mem),
        .req_tag        (req_tag),
        .req_offset     (req_offset),
        .req_len        (req_len),
        .req_data       (req_data)
    );

    tag_array u_tag_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .index        (arr_index),
        .rd_en        (rd_en),
        .req_tag      (req_tag),
        .victim_way   (victim_way),
        .fill         (tag_fill),
        .fill_dirty   (req_write),
        .mark_dirty   (tag_mark_dirty),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    data_array u_data_array (
        .clk       (clk),
        .index     (arr_index),
        .rd_en     (rd_en),
        .wr_en     (data_wr_en),
        .wr_way    (sel_way),     // hit way on a write, victim way on refill
        .wr_line   (merged_line),
        .way0_line (way0_line),
        .way1_line (way1_line)
    );

    line_merge u_line_merge (
        .way0_line   (way0_line),
        .way1_line   (way1_line),
        .sel_way     (sel_way),
        .from_mem    (from_mem),
        .re_data     (re_data),
        .req_offset  (req_offset),
        .req_len     (req_len),
        .req_data    (req_data),
        .write       (req_write),
        .data_out    (data_out),
        .sel_line    (w_data),    // victim line goes straight out on write-back
        .merged_line (merged_line)
    );

endmodule

// ==== rtl/data_array.sv ====
// two ways of 256-bit line storage, synchronous held reads and whole-line writes
`timescale 1ns/1ps

module data_array (
    input  logic              clk,
    input  cache_pkg::index_t index,
    input  logic              rd_en,
    input  logic              wr_en,
    input  logic              wr_way,
    input  cache_pkg::line_t  wr_line,
    output cache_pkg::line_t  way0_line,
    output cache_pkg::line_t  way1_line
);

    localparam int SETS = 1 << cache_pkg::INDEX_W;

    cache_pkg::line_t line_rd [2];

    //////////////////////////////////////////////////
    // one line memory per way
    //////////////////////////////////////////////////
    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_pkg::line_t mem [SETS];
        cache_pkg::line_t q;
        logic             we;

        assign we = wr_en && (wr_way == 1'(w));

        always_ff @(posedge clk) begin
            if (we) begin
                mem[index] <= wr_line;  // full line replace
            end
            if (rd_en) begin
                q <= mem[index];        // kept while idle, victim survives into MISS
            end
        end

        assign line_rd[w] = q;
    end

    assign way0_line = line_rd[0];
    assign way1_line = line_rd[1];

endmodule

// ==== rtl/line_merge.sv ====
// picks the working line, extracts the read word and overlays write data onto the line
`timescale 1ns/1ps

module line_merge (
    input  cache_pkg::line_t   way0_line,
    input  cache_pkg::line_t   way1_line,
    input  logic               sel_way,
    input  logic               from_mem,
    input  cache_pkg::line_t   re_data,
    input  cache_pkg::offset_t req_offset,
    input  cache_pkg::len_t    req_len,
    input  cache_pkg::word_t   req_data,
    input  logic               write,
    output cache_pkg::word_t   data_out,
    output cache_pkg::line_t   sel_line,
    output cache_pkg::line_t   merged_line
);

    cache_pkg::line_t base_line;
    cache_pkg::line_t read_shift;
    cache_pkg::line_t wr_shift;
    cache_pkg::line_t mask_shift;
    cache_pkg::word_t byte_mask;
    logic [7:0]       bit_pos;   // offset in bits

    assign sel_line  = sel_way ? way1_line : way0_line;
    assign base_line = from_mem ? re_data : sel_line; // refill works on the fetched line
    assign bit_pos   = {req_offset, 3'b000};

    // read word, zero filled past the line end
    assign read_shift = base_line >> bit_pos;
    assign data_out   = read_shift[cache_pkg::WORD_W-1:0];

    always_comb begin
        case (req_len)
            2'd0:    byte_mask = 64'h0000_0000_0000_00ff;
            2'd1:    byte_mask = 64'h0000_0000_0000_ffff;
            2'd2:    byte_mask = 64'h0000_0000_ffff_ffff;
            default: byte_mask = 64'hffff_ffff_ffff_ffff;
        endcase
    end

    // bytes shifted past bit 255 fall off
    assign wr_shift   = cache_pkg::line_t'(req_data) << bit_pos;
    assign mask_shift = cache_pkg::line_t'(byte_mask) << bit_pos;

    assign merged_line = write ? ((base_line & ~mask_shift) | (wr_shift & mask_shift))
                               : base_line;

endmodule

// ==== rtl/tag_array.sv ====
// two ways of tags with valid and dirty bits, gives hit, hit way and the victim's tag state
`timescale 1ns/1ps

module tag_array (
    input  logic              clk,
    input  logic              rst_n,
    input  cache_pkg::index_t index,
    input  logic              rd_en,
    input  cache_pkg::tag_t   req_tag,
    input  logic              victim_way,
    input  logic              fill,
    input  logic              fill_dirty,
    input  logic              mark_dirty,
    output logic              hit,
    output logic              hit_way,
    output cache_pkg::tag_t   victim_tag,
    output logic              victim_dirty
);

    localparam int SETS = 1 << cache_pkg::INDEX_W;

    cache_pkg::tag_t tag_rd [2]; // held read per way
    logic [1:0]      valid_rd;
    logic [1:0]      dirty_rd;
    logic [1:0]      way_hit;

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_pkg::tag_t tag_mem [SETS];
        logic [SETS-1:0] valid_bits;
        logic [SETS-1:0] dirty_bits;
        cache_pkg::tag_t tag_q;
        logic            valid_q;
        logic            dirty_q;
        logic            sel_fill;
        logic            sel_mark;

        assign sel_fill = fill && (victim_way == 1'(w));
        assign sel_mark = mark_dirty && (hit_way == 1'(w));

        // tag storage, read held while rd_en is low
        always_ff @(posedge clk) begin
            if (sel_fill) tag_mem[index] <= req_tag;
            if (rd_en) tag_q <= tag_mem[index];
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                valid_bits <= '0;
                dirty_bits <= '0;
                valid_q    <= 1'b0;
                dirty_q    <= 1'b0;
            end else begin
                if (sel_fill) begin
                    valid_bits[index] <= 1'b1;
                    dirty_bits[index] <= fill_dirty;
                end else if (sel_mark) begin
                    dirty_bits[index] <= 1'b1; // write hit
                end
                if (rd_en) begin
                    valid_q <= valid_bits[index];
                    dirty_q <= dirty_bits[index];
                end
            end
        end

        assign tag_rd[w]   = tag_q;
        assign valid_rd[w] = valid_q;
        assign dirty_rd[w] = dirty_q;
        assign way_hit[w]  = valid_q && (tag_q == req_tag);
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    assign victim_tag   = tag_rd[victim_way];
    assign victim_dirty = valid_rd[victim_way] && dirty_rd[victim_way];

    // fill only goes to a way after a miss, so a line never lives in both
    assert property (@(posedge clk) disable iff (!rst_n) !(way_hit[0] && way_hit[1]));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the data cache testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache_top \
    -f sources.f \
    -o sim_cache

./obj_dir/sim_cache

// ==== sources.f ====
rtl/cache_pkg.sv
rtl/tag_array.sv
rtl/data_array.sv
rtl/line_merge.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
test/mem_model.sv
test/tb_cache_top.sv

// ==== test/mem_model.sv ====
// line-wide memory responder for the cache testbench, random ready delays over a backing store
`timescale 1ns/1ps

module mem_model #(
    parameter int unsigned SEED  = 1,
    parameter int          LINES = 1024   // 32 KB backing store
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             r_req,
    input  cache_pkg::addr_t r_addr,
    output logic             r_rdy,
    output cache_pkg::line_t re_data,
    output logic             re_valid,
    input  logic             w_req,
    input  cache_pkg::addr_t w_addr,
    input  cache_pkg::line_t w_data,
    output logic             w_rdy
);

    cache_pkg::line_t mem [LINES];
    int unsigned      rng;
    int               r_wait;     // -1 when no read pending
    int               w_wait;
    int               fill_wait;  // cycles until re_valid
    int               fill_line;

    function automatic int unsigned lcg(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    //////////////////////////////////////////////////
    // backing store fill, mixed with the address
    //////////////////////////////////////////////////
    initial begin
        rng = SEED;
        for (int l = 0; l < LINES; l++) begin
            for (int c = 0; c < 8; c++) begin
                rng = lcg(rng);
                mem[l][c*32 +: 32] = rng ^ {l[15:0], 13'd0, c[2:0]}; // line and chunk in the word
            end
        end
    end

    //////////////////////////////////////////////////
    // responder, drives on the falling edge
    //////////////////////////////////////////////////
    initial begin
        r_rdy     = 1'b0;
        w_rdy     = 1'b0;
        re_valid  = 1'b0;
        re_data   = '0;
        r_wait    = -1;
        w_wait    = -1;
        fill_wait = 0;
        fill_line = 0;
        forever begin
            @(negedge clk);
            r_rdy    = 1'b0;
            w_rdy    = 1'b0;
            re_valid = 1'b0;
            if (rst_n && w_req) begin
                if (w_wait < 0) begin
                    rng    = lcg(rng);
                    w_wait = int'(rng[17:16]); // 0..3 cycles of back-pressure
                end
                if (w_wait == 0) begin
                    w_rdy = 1'b1;
                    mem[int'(w_addr[14:5])] = w_data;
                    w_wait = -1;
                end else begin
                    w_wait--;
                end
            end
            if (rst_n && r_req) begin
                if (r_wait < 0) begin
                    rng    = lcg(rng);
                    r_wait = int'(rng[17:16]);
                end
                if (r_wait == 0) begin
                    r_rdy     = 1'b1;
                    fill_line = int'(r_addr[14:5]);
                    rng       = lcg(rng);
                    fill_wait = 1 + int'(rng[17:16] % 2'd3); // data 1..3 cycles later
                    r_wait    = -1;
                end else begin
                    r_wait--;
                end
            end else if (fill_wait > 0) begin
                fill_wait--;
                if (fill_wait == 0) begin
                    re_valid = 1'b1;                 // single-cycle pulse
                    re_data  = mem[fill_line];
                end
            end
        end
    end

endmodule

// ==== test/tb_cache_top.sv ====
// testbench top that runs a request table through the data cache against a golden byte model
`timescale 1ns/1ps

module tb_cache_top;

    localparam int N         = 26;          // table entries
    localparam int MEM_BYTES = 32768;
    localparam int LIMIT     = 200 * N + 20; // cycle budget incl. reset

    logic             clk;
    logic             rst_n;
    cache_pkg::addr_t addr;
    cache_pkg::word_t data_in;
    logic             valid_in;
    logic             write;
    cache_pkg::len_t  len;
    logic             addr_ok;
    logic             data_ok;
    cache_pkg::word_t data_out;
    logic             r_req;
    cache_pkg::addr_t r_addr;
    logic             r_rdy;
    cache_pkg::line_t re_data;
    logic             re_valid;
    logic             w_req;
    cache_pkg::addr_t w_addr;
    cache_pkg::line_t w_data;
    logic             w_rdy;

    // stimulus table
    logic             tbl_write [N];
    cache_pkg::addr_t tbl_addr  [N];
    cache_pkg::len_t  tbl_len   [N];
    cache_pkg::word_t tbl_data  [N];
    int               tbl_count;

    // golden memory and cache occupancy model
    logic [7:0]       golden [MEM_BYTES];
    logic [20:0]      m_tag   [64][2];
    logic             m_valid [64][2];
    logic             m_dirty [64][2];
    logic             m_victim;
    int               exp_wb;
    int               seen_wb;
    int               exp_rd;
    int               seen_rd;
    cache_pkg::addr_t wb_addr;    // line the next write-back must carry
    cache_pkg::addr_t cur_addr;
    int               cycles;

    cache_top u_cache_top (.*);

    mem_model #(.SEED(93870)) u_mem_model (
        .clk(clk), .rst_n(rst_n),
        .r_req(r_req), .r_addr(r_addr), .r_rdy(r_rdy),
        .re_data(re_data), .re_valid(re_valid),
        .w_req(w_req), .w_addr(w_addr), .w_data(w_data), .w_rdy(w_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    task automatic compare(input logic [255:0] got, input logic [255:0] exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, expected %h, got %h", $time, msg, exp, got);
            $display("Simulation failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic add_entry(input logic w, input cache_pkg::addr_t a, input cache_pkg::len_t l,
                             input cache_pkg::word_t d);
        tbl_write[tbl_count] = w;
        tbl_addr[tbl_count]  = a;
        tbl_len[tbl_count]   = l;
        tbl_data[tbl_count]  = d;
        tbl_count++;
    endtask

    function automatic cache_pkg::word_t expected_read(input cache_pkg::addr_t a);
        cache_pkg::word_t r;
        int               off;
        r   = '0;
        off = int'(a[4:0]);
        for (int i = 0; i < 8; i++) begin
            if (off + i < 32) r[i*8 +: 8] = golden[int'(a[14:0]) + i]; // zero past line end
        end
        return r;
    endfunction

    function automatic cache_pkg::line_t golden_line(input cache_pkg::addr_t a);
        cache_pkg::line_t r;
        int               base;
        base = int'({a[14:5], 5'd0});
        for (int i = 0; i < 32; i++) r[i*8 +: 8] = golden[base + i];
        return r;
    endfunction

    task automatic apply_write(input cache_pkg::addr_t a, input cache_pkg::len_t l,
                               input cache_pkg::word_t d);
        int nbytes;
        nbytes = 1 << int'(l);
        for (int i = 0; i < nbytes; i++) begin
            if (int'(a[4:0]) + i < 32) golden[int'(a[14:0]) + i] = d[i*8 +: 8]; // rest dropped
        end
    endtask

    // occupancy model where the victim flips once per request
    task automatic predict(input logic w, input cache_pkg::addr_t a);
        int s;
        int way;
        s        = int'(a[10:5]);
        way      = -1;
        m_victim = ~m_victim;
        for (int k = 0; k < 2; k++) begin
            if (m_valid[s][k] && m_tag[s][k] == a[31:11]) way = k;
        end
        if (way < 0) begin
            way = int'(m_victim);
            if (m_valid[s][way] && m_dirty[s][way]) begin
                exp_wb++; // clean victims stay quiet
                wb_addr = {m_tag[s][way], 6'(s), 5'd0};
            end
            exp_rd++;
            m_tag[s][way]   = a[31:11];
            m_valid[s][way] = 1'b1;
            m_dirty[s][way] = w;
        end else if (w) begin
            m_dirty[s][way] = 1'b1;
        end
    endtask

    task automatic check_bus_counts();
        compare(256'(seen_wb), 256'(exp_wb), "write-back count");
        compare(256'(seen_rd), 256'(exp_rd), "line fetch count");
    endtask

    task automatic wait_ready();
        @(posedge clk);
        while (!addr_ok) @(posedge clk);
    endtask

    task automatic run_entry(input int k);
        @(negedge clk);
        valid_in = 1'b1;
        write    = tbl_write[k];
        addr     = tbl_addr[k];
        len      = tbl_len[k];
        data_in  = tbl_data[k];
        wait_ready();                 // accepted on this edge
        check_bus_counts();           // previous request has finished
        cur_addr = tbl_addr[k];
        predict(tbl_write[k], tbl_addr[k]);
        if (tbl_write[k]) apply_write(tbl_addr[k], tbl_len[k], tbl_data[k]);
        @(negedge clk);
        valid_in = 1'b0;
        if (!tbl_write[k]) begin
            @(posedge clk);
            while (!data_ok) @(posedge clk);
            compare(256'(data_out), 256'(expected_read(tbl_addr[k])), "read data");
        end
    endtask

    //////////////////////////////////////////////////
    // bus monitor and timeout
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst_n && w_req && w_rdy) begin
            compare(256'(w_addr), 256'(wb_addr), "write-back address");
            compare(w_data, golden_line(w_addr), "write-back line");
            seen_wb++;
        end
        if (rst_n && r_req && r_rdy) begin
            compare(256'(r_addr), 256'({cur_addr[31:5], 5'd0}), "r_addr");
            seen_rd++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout, the run went past %0d cycles without finishing", LIMIT);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        rst_n     = 1'b0;
        valid_in  = 1'b0;
        write     = 1'b0;
        addr      = '0;
        len       = '0;
        data_in   = '0;
        tbl_count = 0;
        cycles    = 0;
        exp_wb    = 0;
        seen_wb   = 0;
        exp_rd    = 0;
        seen_rd   = 0;
        wb_addr   = '0;
        cur_addr  = '0;
        m_victim  = 1'b0;
        for (int s = 0; s < 64; s++) begin
            for (int k = 0; k < 2; k++) begin
                m_tag[s][k]   = '0;
                m_valid[s][k] = 1'b0;
                m_dirty[s][k] = 1'b0;
            end
        end

        // read miss then hits in set 2
        add_entry(1'b0, 32'h0000_0040, 2'd0, 64'h0);
        add_entry(1'b0, 32'h0000_0048, 2'd0, 64'h0);
        add_entry(1'b0, 32'h0000_005c, 2'd0, 64'h0);  // zero fill past end
        // every len at odd offsets and the line end
        add_entry(1'b1, 32'h0000_0041, 2'd0, 64'h0000_0000_0000_00a5);
        add_entry(1'b1, 32'h0000_0046, 2'd1, 64'h0000_0000_0000_beef);
        add_entry(1'b1, 32'h0000_004c, 2'd2, 64'h0000_0000_1234_5678);
        add_entry(1'b1, 32'h0000_0058, 2'd3, 64'h1122_3344_5566_7788);
        add_entry(1'b1, 32'h0000_005d, 2'd3, 64'hcafe_f00d_dead_beef); // 3 bytes kept
        add_entry(1'b0, 32'h0000_0040, 2'd0, 64'h0);
        add_entry(1'b0, 32'h0000_0048, 2'd0, 64'h0);
        add_entry(1'b0, 32'h0000_0058, 2'd0, 64'h0);
        add_entry(1'b0, 32'h0000_005b, 2'd0, 64'h0);
        // write miss in set 3
        add_entry(1'b1, 32'h0000_0863, 2'd2, 64'h0000_0000_0bad_c0de);
        add_entry(1'b0, 32'h0000_0860, 2'd0, 64'h0);
        add_entry(1'b0, 32'h0000_0863, 2'd0, 64'h0);
        // three tags in set 5 with two dirty
        add_entry(1'b1, 32'h0000_08a4, 2'd3, 64'h0102_0304_0506_0708);
        add_entry(1'b1, 32'h0000_10a8, 2'd1, 64'h0000_0000_0000_5a5a);
        add_entry(1'b0, 32'h0000_18a0, 2'd0, 64'h0);
        add_entry(1'b0, 32'h0000_08a4, 2'd0, 64'h0);
        add_entry(1'b0, 32'h0000_10a8, 2'd0, 64'h0);
        add_entry(1'b1, 32'h0000_18b8, 2'd3, 64'hfeed_face_0bad_f00d);
        add_entry(1'b0, 32'h0000_08a0, 2'd0, 64'h0);
        // clean evictions in set 7
        add_entry(1'b0, 32'h0000_20e0, 2'd0, 64'h0);
        add_entry(1'b0, 32'h0000_28e0, 2'd0, 64'h0);
        add_entry(1'b0, 32'h0000_30e0, 2'd0, 64'h0);
        add_entry(1'b0, 32'h0000_20e8, 2'd0, 64'h0);

        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < MEM_BYTES; i++) begin
            golden[i] = u_mem_model.mem[i >> 5][(i & 31) * 8 +: 8]; // start from memory content
        end

        for (int k = 0; k < tbl_count; k++) run_entry(k);

        @(negedge clk);
        wait_ready();                 // last request drained
        check_bus_counts();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
